/* rename_fl.f */
+incdir+testbench
verilog/rename_arch_pkg.sv
verilog/rename_fl_pkg.sv
verilog/freelist.sv
verilog/fl_cam.sv
verilog/rename_map.sv
verilog/rename_fl_top.sv
testbench/rename_fl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rename free-list testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rename_fl.f --top-module rename_fl_tb -o rename_fl_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rename_fl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* testbench/rename_fl_model.svh */
`ifndef RENAME_FL_MODEL_SVH
`define RENAME_FL_MODEL_SVH

// one dispatched lane waiting to retire
typedef struct packed {
	arch_reg_t rd;
	phys_tag_t tag;
	phys_tag_t old;
} inflight_t;

phys_tag_t m_ring [FL_ENTRY_NUM];
phys_tag_t m_spec [ARCH_REG_NUM];
phys_tag_t m_comm [ARCH_REG_NUM];
int        m_head;
int        m_tail;
inflight_t inflight [$];   // oldest first

function automatic void reset_model();
	m_head = 0;
	m_tail = 1;
	for (int i = 0; i < FL_ENTRY_NUM; i++) begin
		if (i == 0) begin
			m_ring[i] = ZERO_PREG;
		end else begin
			m_ring[i] = phys_tag_t'(i + ARCH_REG_NUM);
		end
	end
	for (int r = 0; r < ARCH_REG_NUM; r++) begin
		m_spec[r] = phys_tag_t'(r);
		m_comm[r] = phys_tag_t'(r);
	end
	inflight.delete();
endfunction

// free tags once the oldest rt_n in-flight lanes have retired
function automatic int free_after_retire(input int rt_n);
	int head_now;
	head_now = m_head;
	for (int l = 0; l < rt_n; l++) begin
		if (inflight[l].old != ZERO_PREG) head_now++;
	end
	return (head_now - m_tail + 2 * FL_ENTRY_NUM) % FL_ENTRY_NUM;
endfunction

function automatic void predict_cycle(input lane_cnt_t dp_n, input arch_reg_t [LANES-1:0] rd,
	input int rt_n, input logic rb, output phys_tag_t [LANES-1:0] e_tag,
	output phys_tag_t [LANES-1:0] e_old, output lane_cnt_t e_avail);
	inflight_t ent;
	int free_cnt;
	int n_alloc;
	e_tag = '0;
	e_old = '0;
	free_cnt = free_after_retire(rt_n);
	e_avail = (free_cnt >= 2) ? 2'd2 : lane_cnt_t'(free_cnt);
	for (int l = 0; l < rt_n; l++) begin
		ent = inflight.pop_front();
		if (ent.old != ZERO_PREG) begin   // old tag goes back at the head
			m_ring[m_head] = ent.old;
			m_head = (m_head + 1) % FL_ENTRY_NUM;
		end
		m_comm[ent.rd] = ent.tag;
	end
	if (rb) begin
		// every tag still in flight was allocated after the last retire
		n_alloc = 0;
		foreach (inflight[i]) begin
			if (inflight[i].tag != ZERO_PREG) n_alloc++;
		end
		m_tail = (m_tail - n_alloc + FL_ENTRY_NUM) % FL_ENTRY_NUM;
		inflight.delete();
		m_spec = m_comm;
	end else begin
		for (int l = 0; l < int'(dp_n); l++) begin
			ent.rd = rd[l];
			ent.old = m_spec[rd[l]];   // lane 1 sees lane 0's write
			ent.tag = ZERO_PREG;
			if (rd[l] != '0) begin
				ent.tag = m_ring[m_tail];
				m_tail = (m_tail + 1) % FL_ENTRY_NUM;
			end
			m_spec[rd[l]] = ent.tag;
			e_tag[l] = ent.tag;
			e_old[l] = ent.old;
			inflight.push_back(ent);
		end
	end
endfunction

`endif

/* testbench/rename_fl_tb.sv */
`timescale 1ns/1ps

module rename_fl_tb
	import rename_arch_pkg::*;
	import rename_fl_pkg::*;
();

	`include "rename_fl_model.svh"

	typedef struct packed {
		lane_cnt_t dp_n;
		arch_reg_t rd0;
		arch_reg_t rd1;
		lane_cnt_t rt_n;
		logic      rb;
		logic      rnd;   // rds drawn at random
		logic      chk;   // expected columns valid
		phys_tag_t tag0;
		phys_tag_t tag1;
		phys_tag_t old0;
		phys_tag_t old1;
		lane_cnt_t av;
	} row_t;

	logic                  clk;
	logic                  reset;
	lane_cnt_t             dp_num;
	arch_reg_t [LANES-1:0] dp_rd;
	lane_cnt_t             rt_num;
	arch_reg_t [LANES-1:0] rt_rd;
	phys_tag_t [LANES-1:0] rt_tag;
	phys_tag_t [LANES-1:0] rt_tag_old;
	logic                  rollback;
	phys_tag_t [LANES-1:0] dp_tag;
	phys_tag_t [LANES-1:0] dp_tag_old;
	lane_cnt_t             avail;
	row_t                  stim_q [$];
	int                    err_cnt = 0;
	int                    timeout_cnt = 0;

	rename_fl_top rename_fl_top_inst (
		.clk_i        (clk),
		.reset        (reset),
		.dp_num_i     (dp_num),
		.dp_rd_i      (dp_rd),
		.rt_num_i     (rt_num),
		.rt_rd_i      (rt_rd),
		.rt_tag_i     (rt_tag),
		.rt_tag_old_i (rt_tag_old),
		.rollback_i   (rollback),
		.dp_tag_o     (dp_tag),
		.dp_tag_old_o (dp_tag_old),
		.avail_o      (avail)
	);

	always #50 clk = ~clk;

	task automatic add_row(input int dp_n, input int rd0, input int rd1, input int rt_n,
		input int rb, input int rnd, input int chk, input int tag0, input int tag1,
		input int old0, input int old1, input int av);
		stim_q.push_back({lane_cnt_t'(dp_n), arch_reg_t'(rd0), arch_reg_t'(rd1),
			lane_cnt_t'(rt_n), rb[0], rnd[0], chk[0], phys_tag_t'(tag0), phys_tag_t'(tag1),
			phys_tag_t'(old0), phys_tag_t'(old1), lane_cnt_t'(av)});
	endtask

	task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
		if (got !== exp) begin
			$display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_avail(input string name, input lane_cnt_t got, input lane_cnt_t exp);
		if (got !== exp) begin
			$display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_outputs(input phys_tag_t [LANES-1:0] e_tag,
		input phys_tag_t [LANES-1:0] e_old, input lane_cnt_t e_av);
		for (int l = 0; l < LANES; l++) begin
			check_tag($sformatf("dp_tag_o[%0d]", l), dp_tag[l], e_tag[l]);
			check_tag($sformatf("dp_tag_old_o[%0d]", l), dp_tag_old[l], e_old[l]);
		end
		check_avail("avail_o", avail, e_av);
	endtask

	// trim lanes that the free list cannot serve
	function automatic lane_cnt_t fit_dispatch(input lane_cnt_t dp_n,
		input arch_reg_t [LANES-1:0] rd, input int free_cnt);
		int want0;
		int want1;
		int n;
		want0 = (rd[0] != '0) ? 1 : 0;
		want1 = (rd[1] != '0) ? 1 : 0;
		n = int'(dp_n);
		if (n == 2 && want0 + want1 > free_cnt) n = 1;
		if (n == 1 && want0 > free_cnt) n = 0;
		return lane_cnt_t'(n);
	endfunction

	task automatic drive_inputs(input lane_cnt_t dp_n, input arch_reg_t [LANES-1:0] rd,
		input int rt_n, input logic rb);
		dp_num = dp_n;
		dp_rd = rd;
		rt_num = lane_cnt_t'(rt_n);
		for (int l = 0; l < LANES; l++) begin
			rt_rd[l] = (l < rt_n) ? inflight[l].rd : '0;   // oldest in-flight lanes retire
			rt_tag[l] = (l < rt_n) ? inflight[l].tag : ZERO_PREG;
			rt_tag_old[l] = (l < rt_n) ? inflight[l].old : ZERO_PREG;
		end
		rollback = rb;
	endtask

	task automatic wait_reset_release(output logic released);
		released = (avail === 2'd2);
		for (int c = 0; c < 10 && !released; c++) begin
			@(posedge clk);
			#2;
			released = (avail === 2'd2);
		end
	endtask

	initial begin
		logic                  released;
		row_t                  r;
		arch_reg_t [LANES-1:0] rd;
		lane_cnt_t             dp_n;
		int                    rt_n;
		phys_tag_t [LANES-1:0] e_tag;
		phys_tag_t [LANES-1:0] e_old;
		lane_cnt_t             e_av;
		void'($urandom(32'hc595));
		clk = 1'b0;
		reset = 1'b1;
		drive_inputs('0, '0, 0, 1'b0);
		rt_rd = '0;
		rt_tag = '0;
		rt_tag_old = '0;
		reset_model();

		// dp rd0 rd1 rt rb rnd chk | tag0 tag1 old0 old1 avail
		add_row(0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 2);
		add_row(2, 5, 7, 0, 0, 0, 1, 33, 34, 5, 7, 2);
		add_row(2, 0, 9, 0, 0, 0, 1, 0, 35, 0, 9, 2);    // rd 0 takes no slot
		add_row(1, 3, 0, 0, 0, 0, 1, 36, 0, 3, 0, 2);
		add_row(2, 4, 4, 0, 0, 0, 1, 37, 38, 4, 37, 2);  // shared rd
		repeat (12) add_row(2, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);     // last free tag
		add_row(0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
		add_row(2, 6, 8, 2, 0, 0, 1, 5, 7, 6, 8, 2);     // retire bypass
		add_row(2, 10, 11, 2, 1, 0, 1, 0, 0, 0, 0, 1);
		add_row(2, 9, 3, 0, 0, 0, 1, 36, 37, 35, 3, 2);
		add_row(2, 11, 12, 0, 0, 0, 1, 38, 39, 11, 12, 2);
		add_row(0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 2);
		add_row(0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 2);     // rollback without retire
		add_row(1, 3, 0, 0, 0, 0, 1, 37, 0, 3, 0, 2);
		add_row(2, 0, 0, 2, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(2, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 0, 2, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(2, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(2, 0, 0, 2, 1, 1, 0, 0, 0, 0, 0, 0);
		add_row(2, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(0, 0, 0, 2, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(2, 0, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0);
		add_row(2, 0, 0, 2, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);

		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		wait_reset_release(released);
		if (released) begin
			foreach (stim_q[i]) begin
				r = stim_q[i];
				rd[0] = r.rd0;
				rd[1] = r.rd1;
				if (r.rnd) begin
					// random rds stay above the directed ones
					rd[0] = arch_reg_t'($urandom_range(31, 16));
					rd[1] = arch_reg_t'($urandom_range(31, 16));
				end
				rt_n = (int'(r.rt_n) > inflight.size()) ? inflight.size() : int'(r.rt_n);
				dp_n = r.rb ? r.dp_n : fit_dispatch(r.dp_n, rd, free_after_retire(rt_n));
				@(posedge clk);
				#1;
				drive_inputs(dp_n, rd, rt_n, r.rb);
				predict_cycle(dp_n, rd, rt_n, r.rb, e_tag, e_old, e_av);
				#48;   // settled well before the next edge
				compare_outputs(e_tag, e_old, e_av);
				if (r.chk) compare_outputs({r.tag1, r.tag0}, {r.old1, r.old0}, r.av);
			end
		end else begin
			$display("timeout: avail_o did not come up as 2 after reset was released");
			timeout_cnt++;
		end

		$display("summary: %0d mismatches, %0d timeouts, %0d rows", err_cnt, timeout_cnt,
			stim_q.size());
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verilog/fl_cam.sv */
`timescale 1ns/1ps

module fl_cam
	import rename_arch_pkg::*;
	import rename_fl_pkg::*;
(
	input  logic                   clk_i,
	input  logic                   reset,
	input  phys_tag_t [LANES-1:0]  dp_tag_i,
	input  fl_idx_t   [LANES-1:0]  fl_idx_i,
	input  phys_tag_t              retire_tag_i,
	output fl_idx_t                rollback_idx_o
);

	fl_idx_t cam [PHY_REG_NUM];   // tail position just after each tag went out
	fl_idx_t cam_rd;
	fl_idx_t held_idx;            // index of the last real retire

	assign cam_rd = cam[retire_tag_i];

	// no retire this cycle means fall back to the held index
	assign rollback_idx_o = (retire_tag_i != ZERO_PREG) ? cam_rd : held_idx;

	always_ff @(posedge clk_i) begin
		for (int l = 0; l < LANES; l++) begin
			if (dp_tag_i[l] != ZERO_PREG) begin
				cam[dp_tag_i[l]] <= fl_idx_i[l];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			held_idx <= fl_idx_t'(1);   // tail out of reset
		end else if (retire_tag_i != ZERO_PREG) begin
			held_idx <= cam_rd;
		end
	end

	// lane 1 moved the tail so it must carry a real tag
	a_no_zero_alloc: assert property (@(posedge clk_i) disable iff (reset)
		(fl_idx_i[1] != fl_idx_i[0]) |-> (dp_tag_i[1] != ZERO_PREG));

	// one group never gets the same tag twice
	a_distinct_tags: assert property (@(posedge clk_i) disable iff (reset)
		(dp_tag_i[0] != ZERO_PREG) |-> (dp_tag_i[1] != dp_tag_i[0]));

endmodule

/* verilog/freelist.sv */
`timescale 1ns/1ps

module freelist
	import rename_arch_pkg::*;
	import rename_fl_pkg::*;
(
	input  logic                   clk_i,
	input  logic                   reset,
	input  logic                   rollback_i,
	input  lane_cnt_t              dp_num_i,
	input  arch_reg_t [LANES-1:0]  dp_rd_i,
	input  lane_cnt_t              rt_num_i,
	input  phys_tag_t [LANES-1:0]  rt_tag_i,
	input  phys_tag_t [LANES-1:0]  rt_tag_old_i,
	input  fl_idx_t                rollback_idx_i,
	output phys_tag_t [LANES-1:0]  dp_tag_o,
	output fl_idx_t   [LANES-1:0]  fl_idx_o,
	output phys_tag_t              retire_tag_sel_o,
	output lane_cnt_t              avail_o
);

	phys_tag_t [FL_ENTRY_NUM-1:0] fl_entry;
	phys_tag_t [FL_ENTRY_NUM-1:0] next_fl_entry;   // with this cycle's retires
	fl_idx_t          head;      // next slot to receive a retired tag
	fl_idx_t          rt_head;   // head after retire
	fl_idx_t          tail;      // next tag to hand out
	fl_idx_t          dp_tail;   // tail after dispatch
	fl_idx_t          next_tail;
	logic [LANES-1:0] alloc;     // lane takes a new tag
	logic [LANES-1:0] rt_free;   // lane returns its old tag
	lane_cnt_t        alloc_cnt;

	// a dispatch in a rollback cycle is dropped
	assign alloc[0] = !rollback_i && (dp_num_i >= 2'd1) && (dp_rd_i[0] != '0);
	assign alloc[1] = !rollback_i && (dp_num_i == 2'd2) && (dp_rd_i[1] != '0);
	assign alloc_cnt = lane_cnt_t'(alloc[0]) + lane_cnt_t'(alloc[1]);

	assign rt_free[0] = (rt_num_i >= 2'd1) && (rt_tag_old_i[0] != ZERO_PREG);
	assign rt_free[1] = (rt_num_i == 2'd2) && (rt_tag_old_i[1] != ZERO_PREG);

	// retire writes old tags at the head, lane 0 first
	always_comb begin
		next_fl_entry = fl_entry;
		rt_head = head;
		for (int l = 0; l < LANES; l++) begin
			if (rt_free[l]) begin
				next_fl_entry[rt_head] = rt_tag_old_i[l];
				rt_head = rt_head + fl_idx_t'(1);
			end
		end
	end

	// youngest retiring instruction that really owned a tag
	assign retire_tag_sel_o = rt_free[1] ? rt_tag_i[1] :
		rt_free[0] ? rt_tag_i[0] : ZERO_PREG;

	// dispatch reads the bypassed slots so a tag freed now can go out now
	always_comb begin
		dp_tail = tail;
		for (int l = 0; l < LANES; l++) begin
			dp_tag_o[l] = ZERO_PREG;
			if (alloc[l]) begin
				dp_tag_o[l] = next_fl_entry[dp_tail];
				dp_tail = dp_tail + fl_idx_t'(1);
			end
			fl_idx_o[l] = dp_tail;   // tail after this lane, kept by the cam
		end
	end

	assign next_tail = rollback_i ? rollback_idx_i : dp_tail;

	assign avail_o = (rt_head == tail) ? 2'd0 :                     // empty
		(rt_head == tail + fl_idx_t'(1)) ? 2'd1 : 2'd2;

	always_ff @(posedge clk_i) begin
		if (reset) begin
			head <= '0;
			tail <= fl_idx_t'(1);
			for (int i = 0; i < FL_ENTRY_NUM; i++) begin
				if (i == 0) begin
					fl_entry[i] <= ZERO_PREG;
				end else begin
					fl_entry[i] <= phys_tag_t'(i + ARCH_REG_NUM);   // tags 33 to 63
				end
			end
		end else begin
			head <= rt_head;
			tail <= next_tail;
			fl_entry <= next_fl_entry;
		end
	end

	// no stall path, the dispatch source has to respect avail_o
	a_alloc_le_avail: assert property (@(posedge clk_i) disable iff (reset)
		alloc_cnt <= avail_o);

	// free slots plus this cycle's returns must stay behind the tail
	a_head_behind_tail: assert property (@(posedge clk_i) disable iff (reset)
		(int'(fl_idx_t'(head - tail)) + int'(rt_free[0]) + int'(rt_free[1]))
			< FL_ENTRY_NUM);

endmodule

/* verilog/rename_arch_pkg.sv */
package rename_arch_pkg;

	localparam int ARCH_REG_NUM = 32;
	localparam int PHY_REG_NUM = 64;
	localparam int PHY_TAG_W = 6;   // log2 of PHY_REG_NUM
	localparam int LANES = 2;       // dispatch and retire width

	// physical register tag
	typedef logic [PHY_TAG_W-1:0] phys_tag_t;

	// architectural register number
	typedef logic [$clog2(ARCH_REG_NUM)-1:0] arch_reg_t;

	// hard-wired zero register, never handed out
	localparam phys_tag_t ZERO_PREG = '0;

endpackage

/* verilog/rename_fl_pkg.sv */
package rename_fl_pkg;

	localparam int FL_ENTRY_NUM = 32;   // slots in the circular list

	// slot index, wraps at FL_ENTRY_NUM
	typedef logic [$clog2(FL_ENTRY_NUM)-1:0] fl_idx_t;

	// 0, 1 or 2 lanes
	typedef logic [1:0] lane_cnt_t;

endpackage

/* verilog/rename_fl_top.sv */
`timescale 1ns/1ps

module rename_fl_top
	import rename_arch_pkg::*;
	import rename_fl_pkg::*;
(
	input  logic                   clk_i,
	input  logic                   reset,
	input  lane_cnt_t              dp_num_i,
	input  arch_reg_t [LANES-1:0]  dp_rd_i,
	input  lane_cnt_t              rt_num_i,
	input  arch_reg_t [LANES-1:0]  rt_rd_i,
	input  phys_tag_t [LANES-1:0]  rt_tag_i,
	input  phys_tag_t [LANES-1:0]  rt_tag_old_i,
	input  logic                   rollback_i,
	output phys_tag_t [LANES-1:0]  dp_tag_o,
	output phys_tag_t [LANES-1:0]  dp_tag_old_o,
	output lane_cnt_t              avail_o
);

	fl_idx_t [LANES-1:0] fl_idx;
	phys_tag_t           retire_tag_sel;
	fl_idx_t             rollback_idx;

	freelist freelist_inst (
		.clk_i            (clk_i),
		.reset            (reset),
		.rollback_i       (rollback_i),
		.dp_num_i         (dp_num_i),
		.dp_rd_i          (dp_rd_i),
		.rt_num_i         (rt_num_i),
		.rt_tag_i         (rt_tag_i),
		.rt_tag_old_i     (rt_tag_old_i),
		.rollback_idx_i   (rollback_idx),
		.dp_tag_o         (dp_tag_o),
		.fl_idx_o         (fl_idx),
		.retire_tag_sel_o (retire_tag_sel),
		.avail_o          (avail_o)
	);

	fl_cam fl_cam_inst (
		.clk_i          (clk_i),
		.reset          (reset),
		.dp_tag_i       (dp_tag_o),
		.fl_idx_i       (fl_idx),
		.retire_tag_i   (retire_tag_sel),
		.rollback_idx_o (rollback_idx)
	);

	rename_map rename_map_inst (
		.clk_i        (clk_i),
		.reset        (reset),
		.rollback_i   (rollback_i),
		.dp_num_i     (dp_num_i),
		.dp_rd_i      (dp_rd_i),
		.dp_tag_i     (dp_tag_o),
		.rt_num_i     (rt_num_i),
		.rt_rd_i      (rt_rd_i),
		.rt_tag_i     (rt_tag_i),
		.dp_tag_old_o (dp_tag_old_o)
	);

endmodule

/* verilog/rename_map.sv */
`timescale 1ns/1ps

module rename_map
	import rename_arch_pkg::*;
	import rename_fl_pkg::*;
(
	input  logic                   clk_i,
	input  logic                   reset,
	input  logic                   rollback_i,
	input  lane_cnt_t              dp_num_i,
	input  arch_reg_t [LANES-1:0]  dp_rd_i,
	input  phys_tag_t [LANES-1:0]  dp_tag_i,
	input  lane_cnt_t              rt_num_i,
	input  arch_reg_t [LANES-1:0]  rt_rd_i,
	input  phys_tag_t [LANES-1:0]  rt_tag_i,
	output phys_tag_t [LANES-1:0]  dp_tag_old_o
);

	phys_tag_t spec_map [ARCH_REG_NUM];    // speculative, written at dispatch
	phys_tag_t comm_map [ARCH_REG_NUM];    // committed, written at retire
	phys_tag_t next_spec [ARCH_REG_NUM];
	phys_tag_t next_comm [ARCH_REG_NUM];
	logic [LANES-1:0] dp_act;
	logic [LANES-1:0] rt_act;

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			dp_act[l] = !rollback_i && (int'(dp_num_i) > l);
			rt_act[l] = int'(rt_num_i) > l;
		end
	end

	assign dp_tag_old_o[0] = dp_act[0] ? spec_map[dp_rd_i[0]] : ZERO_PREG;

	// same rd in both lanes, lane 1 replaces what lane 0 just mapped
	assign dp_tag_old_o[1] = !dp_act[1] ? ZERO_PREG :
		(dp_rd_i[1] == dp_rd_i[0]) ? dp_tag_i[0] : spec_map[dp_rd_i[1]];

	// younger lane wins on a shared rd
	always_comb begin
		next_comm = comm_map;
		for (int l = 0; l < LANES; l++) begin
			if (rt_act[l]) begin
				next_comm[rt_rd_i[l]] = rt_tag_i[l];
			end
		end
	end

	always_comb begin
		next_spec = spec_map;
		if (rollback_i) begin
			next_spec = next_comm;   // includes this cycle's retires
		end else begin
			for (int l = 0; l < LANES; l++) begin
				if (dp_act[l]) begin
					next_spec[dp_rd_i[l]] = dp_tag_i[l];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			for (int r = 0; r < ARCH_REG_NUM; r++) begin
				spec_map[r] <= phys_tag_t'(r);   // identity map
				comm_map[r] <= phys_tag_t'(r);
			end
		end else begin
			spec_map <= next_spec;
			comm_map <= next_comm;
		end
	end

endmodule
